//--- compile.f
hdl/uart_calc_pkg.sv
hdl/calc_ifs.sv
hdl/uart_rx.sv
hdl/cmd_decode.sv
hdl/alu_execute.sv
hdl/result_serializer.sv
hdl/uart_tx.sv
hdl/uart_calc_top.sv
verif/uart_calc_tb.sv

//--- hdl/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
	input logic i_clk,
	input logic i_rst,
	op_if.sink  i_op,
	res_if.source o_res
);
	import uart_calc_pkg::*;

	logic [DATA_BITS:0]   outcome;
	logic                 take;
	logic                 res_valid;
	logic [DATA_BITS-1:0] res_value;
	logic                 res_carry;
	logic                 res_zero;

	// One result slot, so a new command waits until the old one leaves
	assign i_op.ready = !res_valid;
	assign take       = i_op.valid && i_op.ready;

	assign o_res.valid = res_valid;
	assign o_res.value = res_value;
	assign o_res.carry = res_carry;
	assign o_res.zero  = res_zero;

	// Bit 8 of the outcome becomes the carry flag
	always_comb begin
		case (i_op.op)
			OP_ADD:  outcome = {1'b0, i_op.a} + {1'b0, i_op.b};
			OP_SUB:  outcome = {1'b0, i_op.a} - {1'b0, i_op.b};
			OP_AND:  outcome = {1'b0, i_op.a & i_op.b};
			OP_OR:   outcome = {1'b0, i_op.a | i_op.b};
			OP_XOR:  outcome = {1'b0, i_op.a ^ i_op.b};
			OP_SHL:  outcome = {i_op.a, 1'b0};
			OP_SHR:  outcome = {i_op.a[0], 1'b0, i_op.a[DATA_BITS-1:1]};
			OP_PASS: outcome = {1'b0, i_op.b};
			default: outcome = '0;
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst)
			res_valid <= 1'b0;
		else if (take)
			res_valid <= 1'b1;
		else if (res_valid && o_res.ready)
			res_valid <= 1'b0;
	end

	always_ff @(posedge i_clk) begin
		if (take) begin
			res_value <= outcome[DATA_BITS-1:0];
			res_carry <= outcome[DATA_BITS];
			res_zero  <= (outcome[DATA_BITS-1:0] == '0);
		end
	end

	assert property (@(posedge i_clk) disable iff (i_rst)
		o_res.valid && !o_res.ready |=>
			o_res.valid && $stable(o_res.value) && $stable(o_res.carry) && $stable(o_res.zero))
		else $error("alu_execute: result replaced while still held");

endmodule

//--- hdl/calc_ifs.sv
`timescale 1ns/1ps

// Decoded command travelling from the command decoder to the ALU
interface op_if;
	import uart_calc_pkg::*;

	logic                 valid;
	op_e                  op;
	logic [DATA_BITS-1:0] a;
	logic [DATA_BITS-1:0] b;
	logic                 ready;

	modport source (
		output valid,
		output op,
		output a,
		output b,
		input  ready
	);

	modport sink (
		input  valid,
		input  op,
		input  a,
		input  b,
		output ready
	);
endinterface

// Registered ALU result waiting for the reply sequencer
interface res_if;
	import uart_calc_pkg::*;

	logic                 valid;
	logic [DATA_BITS-1:0] value;
	logic                 carry;
	logic                 zero;
	logic                 ready;

	modport source (
		output valid,
		output value,
		output carry,
		output zero,
		input  ready
	);

	modport sink (
		input  valid,
		input  value,
		input  carry,
		input  zero,
		output ready
	);
endinterface

//--- hdl/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
	input  logic                                i_clk,
	input  logic                                i_rst,
	input  logic [uart_calc_pkg::DATA_BITS-1:0] i_byte,
	input  logic                                i_valid,
	input  logic                                i_frame_err,
	output logic                                o_cmd_error,
	op_if.source                                o_op
);
	import uart_calc_pkg::*;

	logic [1:0]           byte_cnt;
	logic [DATA_BITS-1:0] op_byte;
	logic [DATA_BITS-1:0] a_byte;
	logic                 op_ok;
	logic                 slot_busy;
	logic                 last_byte;
	logic                 load;
	logic                 cmd_valid;
	op_e                  cmd_op;
	logic [DATA_BITS-1:0] cmd_a;
	logic [DATA_BITS-1:0] cmd_b;

	// Only the low bits name an operation, anything above must be zero
	assign op_ok     = (op_byte[DATA_BITS-1:$bits(op_e)] == '0);
	assign slot_busy = cmd_valid && !o_op.ready;
	assign last_byte = i_valid && (byte_cnt == 2'd2);
	assign load      = last_byte && op_ok && !slot_busy;

	assign o_op.valid = cmd_valid;
	assign o_op.op    = cmd_op;
	assign o_op.a     = cmd_a;
	assign o_op.b     = cmd_b;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			byte_cnt    <= '0;
			cmd_valid   <= 1'b0;
			o_cmd_error <= 1'b0;
		end else begin
			o_cmd_error <= 1'b0;
			if (cmd_valid && o_op.ready)
				cmd_valid <= 1'b0;
			if (i_frame_err) begin
				byte_cnt    <= '0;
				o_cmd_error <= 1'b1;
			end else if (i_valid) begin
				if (byte_cnt == 2'd2) begin
					byte_cnt <= '0;
					// A third byte lands either in the free slot or as an error
					if (load)
						cmd_valid <= 1'b1;
					else
						o_cmd_error <= 1'b1;
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid && byte_cnt == 2'd0)
			op_byte <= i_byte;
		if (i_valid && byte_cnt == 2'd1)
			a_byte <= i_byte;
		if (load) begin
			cmd_op <= op_e'(op_byte[$bits(op_e)-1:0]);
			cmd_a  <= a_byte;
			cmd_b  <= i_byte;
		end
	end

	assert property (@(posedge i_clk) disable iff (i_rst)
		o_op.valid && !o_op.ready |=>
			o_op.valid && $stable(o_op.op) && $stable(o_op.a) && $stable(o_op.b))
		else $error("cmd_decode: held command changed before the ALU took it");

endmodule

//--- hdl/result_serializer.sv
`timescale 1ns/1ps

module result_serializer (
	input  logic                                i_clk,
	input  logic                                i_rst,
	res_if.sink                                 i_res,
	output logic [uart_calc_pkg::DATA_BITS-1:0] o_tx_data,
	output logic                                o_tx_ready,
	input  logic                                i_tx_done
);
	import uart_calc_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_VALUE, S_FLAGS} state_e;

	state_e               state;
	logic                 accept;
	logic [DATA_BITS-1:0] flags;
	logic [DATA_BITS-1:0] flags_q;
	logic                 tx_busy;

	assign i_res.ready = (state == S_IDLE);
	assign accept      = i_res.valid && i_res.ready;

	always_comb begin
		flags             = '0;
		flags[FLAG_CARRY] = i_res.carry;
		flags[FLAG_ZERO]  = i_res.zero;
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state      <= S_IDLE;
			o_tx_ready <= 1'b0;
		end else begin
			o_tx_ready <= 1'b0;
			case (state)
				S_IDLE: begin
					if (accept) begin
						state      <= S_VALUE;
						o_tx_ready <= 1'b1;
					end
				end
				S_VALUE: begin
					if (i_tx_done) begin
						state      <= S_FLAGS;
						o_tx_ready <= 1'b1;
					end
				end
				S_FLAGS: begin
					if (i_tx_done)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Value byte goes out first, the flags follow from the saved copy
	always_ff @(posedge i_clk) begin
		if (accept) begin
			o_tx_data <= i_res.value;
			flags_q   <= flags;
		end else if (state == S_VALUE && i_tx_done) begin
			o_tx_data <= flags_q;
		end
	end

	// Tracks the transmitter between a strobe and its done pulse
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst)
			tx_busy <= 1'b0;
		else if (o_tx_ready)
			tx_busy <= 1'b1;
		else if (i_tx_done)
			tx_busy <= 1'b0;
	end

	assert property (@(posedge i_clk) disable iff (i_rst) o_tx_ready |-> !tx_busy)
		else $error("result_serializer: byte strobed while the transmitter is busy");

endmodule

//--- hdl/uart_calc_pkg.sv
package uart_calc_pkg;

	// Serial timing, 8N1 with a fixed bit period
	localparam int CLKS_PER_BIT = 16;
	localparam int DATA_BITS    = 8;

	// Operation codes carried in the low bits of the first command byte
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SHL  = 3'd5,
		OP_SHR  = 3'd6,
		OP_PASS = 3'd7
	} op_e;

	// Bit positions in the reply flags byte, the remaining bits read as zero
	localparam int FLAG_CARRY = 0;
	localparam int FLAG_ZERO  = 1;

endpackage

//--- hdl/uart_calc_top.sv
`timescale 1ns/1ps

module uart_calc_top (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_rx,
	output logic o_tx,
	output logic o_cmd_error
);
	import uart_calc_pkg::*;

	logic [DATA_BITS-1:0] rx_byte;
	logic                 rx_valid;
	logic                 rx_frame_err;
	logic [DATA_BITS-1:0] tx_data;
	logic                 tx_ready;
	logic                 tx_done;

	op_if  op_bus ();
	res_if res_bus ();

	uart_rx u_rx (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_rx        (i_rx),
		.o_byte      (rx_byte),
		.o_valid     (rx_valid),
		.o_frame_err (rx_frame_err)
	);

	cmd_decode u_decode (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_byte      (rx_byte),
		.i_valid     (rx_valid),
		.i_frame_err (rx_frame_err),
		.o_cmd_error (o_cmd_error),
		.o_op        (op_bus.source)
	);

	alu_execute u_execute (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_op  (op_bus.sink),
		.o_res (res_bus.source)
	);

	result_serializer u_result (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_res      (res_bus.sink),
		.o_tx_data  (tx_data),
		.o_tx_ready (tx_ready),
		.i_tx_done  (tx_done)
	);

	uart_tx u_tx (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_data       (tx_data),
		.i_data_ready (tx_ready),
		.o_tx         (o_tx),
		.o_tx_done    (tx_done)
	);

endmodule

//--- hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input  logic                                i_clk,
	input  logic                                i_rst,
	input  logic                                i_rx,
	output logic [uart_calc_pkg::DATA_BITS-1:0] o_byte,
	output logic                                o_valid,
	output logic                                o_frame_err
);
	import uart_calc_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_e;

	state_e                          state;
	logic [1:0]                      sync;
	logic                            rx_s;
	logic                            rx_prev;
	logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
	logic [$clog2(DATA_BITS)-1:0]    bit_cnt;
	logic                            bit_tick;
	logic [DATA_BITS-1:0]            shift;

	assign rx_s     = sync[1];
	assign bit_tick = (clk_cnt == CLKS_PER_BIT - 1);
	assign o_byte   = shift;

	// Line idles high, so the synchronizer comes out of reset at one
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			sync    <= 2'b11;
			rx_prev <= 1'b1;
		end else begin
			sync    <= {sync[0], i_rx};
			rx_prev <= rx_s;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state       <= S_IDLE;
			clk_cnt     <= '0;
			bit_cnt     <= '0;
			o_valid     <= 1'b0;
			o_frame_err <= 1'b0;
		end else begin
			o_valid     <= 1'b0;
			o_frame_err <= 1'b0;
			clk_cnt     <= clk_cnt + 1'b1;
			case (state)
				S_IDLE: begin
					clk_cnt <= '0;
					if (rx_prev && !rx_s)
						state <= S_START;
				end
				S_START: begin
					// Mid start bit, a high line here was only a glitch
					if (clk_cnt == CLKS_PER_BIT / 2 - 1) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rx_s ? S_IDLE : S_DATA;
					end
				end
				S_DATA: begin
					if (bit_tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == DATA_BITS - 1)
							state <= S_STOP;
					end
				end
				S_STOP: begin
					if (bit_tick) begin
						state <= S_IDLE;
						if (rx_s)
							o_valid <= 1'b1;
						else
							o_frame_err <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// LSB arrives first, so bits enter at the top and move down
	always_ff @(posedge i_clk) begin
		if (state == S_DATA && bit_tick)
			shift <= {rx_s, shift[DATA_BITS-1:1]};
	end

	assert property (@(posedge i_clk) disable iff (i_rst) !(o_valid && o_frame_err))
		else $error("uart_rx: byte strobe and framing error in the same cycle");

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
	input  logic                                i_clk,
	input  logic                                i_rst,
	input  logic [uart_calc_pkg::DATA_BITS-1:0] i_data,
	input  logic                                i_data_ready,
	output logic                                o_tx,
	output logic                                o_tx_done
);
	import uart_calc_pkg::*;

	typedef enum logic {S_IDLE, S_SEND} state_e;

	state_e                            state;
	logic [DATA_BITS+1:0]              frame;
	logic [$clog2(CLKS_PER_BIT)-1:0]   clk_cnt;
	logic [$clog2(DATA_BITS+2)-1:0]    bit_cnt;

	// The line is the bottom of the frame register, ones fill in behind it
	assign o_tx = frame[0];

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state     <= S_IDLE;
			frame     <= '1;
			clk_cnt   <= '0;
			bit_cnt   <= '0;
			o_tx_done <= 1'b0;
		end else begin
			o_tx_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_data_ready) begin
						// stop bit, data, start bit
						frame   <= {1'b1, i_data, 1'b0};
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= S_SEND;
					end
				end
				S_SEND: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (clk_cnt == CLKS_PER_BIT - 1) begin
						frame <= {1'b1, frame[DATA_BITS+1:1]};
						if (bit_cnt == DATA_BITS + 1) begin
							state     <= S_IDLE;
							o_tx_done <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the calculator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module uart_calc_tb -f compile.f \
	&& ./obj_dir/Vuart_calc_tb \
	|| exit 1

//--- verif/uart_calc_tb.sv
`timescale 1ns/1ps

module uart_calc_tb;
	import uart_calc_pkg::*;

	// Roughly 48 commands in all, each about 800 clocks with its reply
	localparam int CMD_BUDGET     = 50;
	localparam int CLKS_PER_CMD   = 800;
	localparam int TIMEOUT_CYCLES = CMD_BUDGET * CLKS_PER_CMD;
	localparam int BIT_CLKS       = 16;

	logic i_clk;
	logic i_rst;
	logic i_rx;
	logic o_tx;
	logic o_cmd_error;

	logic [15:0] exp_q[$];
	string       name_q[$];
	int          errors_expected;
	int          err_count;
	int          cycle_count;

	uart_calc_top uart_calc_top_inst (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_rx        (i_rx),
		.o_tx        (o_tx),
		.o_cmd_error (o_cmd_error)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	task automatic report_failure(input string what);
		$display("ERROR: %s", what);
		$display("Result: FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		$display("Result: FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// Reply as {result byte, flags byte}, worked out in integer arithmetic
	function automatic logic [15:0] expected_reply(input logic [2:0] op, input logic [7:0] a,
			input logic [7:0] b);
		int         ai;
		int         bi;
		int         r;
		logic       carry;
		logic [7:0] res;
		logic [7:0] flags;
		ai    = int'(a);
		bi    = int'(b);
		r     = 0;
		carry = 1'b0;
		case (op)
			OP_ADD: begin
				r     = ai + bi;
				carry = (r > 255);
			end
			OP_SUB: begin
				r     = ai - bi;
				carry = (ai < bi);
			end
			OP_AND: r = ai & bi;
			OP_OR:  r = ai | bi;
			OP_XOR: r = ai ^ bi;
			OP_SHL: begin
				r     = ai * 2;
				carry = a[7];
			end
			OP_SHR: begin
				r     = ai / 2;
				carry = a[0];
			end
			OP_PASS: r = bi;
			default: r = 0;
		endcase
		res               = 8'(r);
		flags             = 8'h00;
		flags[FLAG_CARRY] = carry;
		flags[FLAG_ZERO]  = (res == 8'h00);
		return {res, flags};
	endfunction

	// Called on a falling edge, returns on a falling edge
	task automatic send_frame(input logic [7:0] data, input logic bad_stop);
		logic [9:0] bits;
		int         i;
		bits = {~bad_stop, data, 1'b0};
		for (i = 0; i < 10; i++) begin
			i_rx = bits[i];
			repeat (BIT_CLKS) @(negedge i_clk);
		end
		// A low stop bit needs some idle line before the next start edge
		if (bad_stop) begin
			i_rx = 1'b1;
			repeat (2 * BIT_CLKS) @(negedge i_clk);
		end
	endtask

	task automatic send_command(input string name, input logic [7:0] op_byte,
			input logic [7:0] a, input logic [7:0] b);
		if (op_byte[7:3] == 5'd0) begin
			exp_q.push_back(expected_reply(op_byte[2:0], a, b));
			name_q.push_back(name);
		end else begin
			errors_expected++;
		end
		send_frame(op_byte, 1'b0);
		send_frame(a, 1'b0);
		send_frame(b, 1'b0);
	endtask

	task automatic wait_replies();
		while (exp_q.size() != 0)
			@(negedge i_clk);
	endtask

	task automatic wait_errors();
		while (err_count < errors_expected)
			@(negedge i_clk);
	endtask

	task automatic run_check(input string name, input logic [2:0] op, input logic [7:0] a,
			input logic [7:0] b);
		send_command(name, {5'd0, op}, a, b);
		wait_replies();
	endtask

	// Decodes one o_tx frame and checks that edges sit on the bit grid
	task automatic receive_byte(output logic [7:0] data);
		int   k;
		logic prev;
		do
			@(negedge i_clk);
		while (i_rst || o_tx !== 1'b0);
		prev = 1'b0;
		data = 8'h00;
		for (k = 1; k < 10 * BIT_CLKS; k++) begin
			@(negedge i_clk);
			if (o_tx !== prev) begin
				assert (k % BIT_CLKS == 0)
					else report_failure("reply bit edge is off the 16 clock bit grid");
			end
			prev = o_tx;
			if (k % BIT_CLKS == BIT_CLKS / 2) begin
				if (k / BIT_CLKS >= 1 && k / BIT_CLKS <= 8)
					data[k / BIT_CLKS - 1] = o_tx;
				else if (k / BIT_CLKS == 9)
					assert (o_tx === 1'b1) else report_failure("reply stop bit is not high");
			end
		end
	endtask

	initial begin : reply_monitor
		logic [7:0]  value;
		logic [7:0]  flags;
		logic [15:0] exp;
		string       name;
		forever begin
			receive_byte(value);
			receive_byte(flags);
			if (exp_q.size() == 0) begin
				report_failure("reply arrived with no command outstanding");
			end else begin
				exp  = exp_q.pop_front();
				name = name_q.pop_front();
				assert (value == exp[15:8])
					else report_mismatch({name, " result"}, 32'(exp[15:8]), 32'(value));
				assert (flags == exp[7:0])
					else report_mismatch({name, " flags"}, 32'(exp[7:0]), 32'(flags));
			end
		end
	end

	always @(negedge i_clk) begin
		if (!i_rst && o_cmd_error === 1'b1) begin
			err_count++;
			assert (err_count <= errors_expected)
				else report_failure("o_cmd_error pulsed with no bad command sent");
		end
	end

	always @(posedge i_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_failure("timeout, the run hung before all replies came back");
	end

	initial begin : stimulus
		logic [2:0] op;
		logic [7:0] a;
		logic [7:0] b;
		int         i;
		void'($urandom(36));
		i_rst           = 1'b1;
		i_rx            = 1'b1;
		errors_expected = 0;
		err_count       = 0;
		cycle_count     = 0;
		repeat (10) @(negedge i_clk);
		i_rst = 1'b0;

		for (i = 0; i < 64; i++) begin
			@(negedge i_clk);
			assert (o_tx === 1'b1 && o_cmd_error === 1'b0)
				else report_failure("outputs not idle after reset");
		end

		run_check("add_carry", OP_ADD, 8'hFF, 8'h01);
		run_check("add_plain", OP_ADD, 8'h12, 8'h34);
		run_check("sub_borrow", OP_SUB, 8'h00, 8'h01);
		run_check("sub_equal", OP_SUB, 8'h5C, 8'h5C);
		run_check("and_zero", OP_AND, 8'hF0, 8'h0F);
		run_check("or_mix", OP_OR, 8'hA0, 8'h05);
		run_check("xor_equal", OP_XOR, 8'h5A, 8'h5A);
		run_check("shl_top", OP_SHL, 8'h80, 8'h33);
		run_check("shl_low", OP_SHL, 8'h01, 8'h00);
		run_check("shr_low", OP_SHR, 8'h01, 8'hFF);
		run_check("shr_top", OP_SHR, 8'h80, 8'h00);
		run_check("pass_zero", OP_PASS, 8'h77, 8'h00);
		run_check("pass_byte", OP_PASS, 8'h00, 8'hA5);

		// Back to back, so the next command arrives while a reply goes out
		for (i = 0; i < 30; i++) begin
			op = 3'($urandom);
			a  = 8'($urandom);
			b  = 8'($urandom);
			send_command($sformatf("random_%0d", i), {5'd0, op}, a, b);
		end
		wait_replies();

		send_command("bad_op_top", 8'h80, 8'h11, 8'h22);
		wait_errors();
		send_command("bad_op_rand", {5'($urandom % 31 + 1), 3'($urandom)}, 8'h01, 8'h02);
		wait_errors();
		run_check("after_bad_op", OP_ADD, 8'h40, 8'h41);

		errors_expected++;
		send_frame({5'd0, OP_XOR}, 1'b0);
		send_frame(8'h3C, 1'b1);
		wait_errors();
		send_command("after_frame_err", {5'd0, OP_SUB}, 8'h10, 8'h20);

		// The reply takes 20 bit-times after the last stop bit, plus a little slack
		repeat (22 * BIT_CLKS) @(negedge i_clk);
		if (exp_q.size() == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			report_mismatch("final_queue", 32'd0, 32'(exp_q.size()));
		end
	end

endmodule
